// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module lsu_tb

sim:
	verilator --binary --timing -f flist.f --top-module lsu_tb -o lsu_sim
	./obj_dir/lsu_sim > sim.log 2>&1; cat sim.log
	grep -q '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

// File: flist.f
lsu_pkg.sv
lsu_opcode_decoder.sv
lsu_addr_calculator.sv
lsu_lane_sequencer.sv
lsu_lane_buffer.sv
lsu_op_manager.sv
lsu.sv
lsu_tb.sv

// File: lsu.sv
`timescale 1ns/10ps
`default_nettype none

module lsu #(
    parameter int NUM_LANES = 4
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      issue_lsu_select,
    input  wire lsu_pkg::lsu_issue_t                 issue,
    input  wire [NUM_LANES-1:0]                      exec_mask,
    output logic                                     issue_ready,
    output lsu_pkg::lsu_gpr_rd_t                     gpr_rd,
    input  wire [lsu_pkg::word_w-1:0]                sgpr_source1_data,
    input  wire [lsu_pkg::word_w-1:0]                sgpr_source2_data,
    input  wire [NUM_LANES-1:0][lsu_pkg::word_w-1:0] vgpr_source1_data,
    input  wire [NUM_LANES-1:0][lsu_pkg::word_w-1:0] vgpr_source2_data,
    output lsu_pkg::lsu_mem_req_t                    mem_req,
    input  wire                                      mem_ack,
    input  wire [lsu_pkg::word_w-1:0]                mem_rd_data,
    output lsu_pkg::lsu_wb_t                         wb,
    output lsu_pkg::lsu_done_t                       done
);

    lsu_pkg::lsu_decoded_t decoded;
    lsu_pkg::lsu_opcode_u opcode_q;
    logic [15:0] lds_base_q;
    logic [NUM_LANES-1:0][lsu_pkg::word_w-1:0] addrs;
    logic [NUM_LANES-1:0][lsu_pkg::word_w-1:0] result;
    logic [lsu_pkg::word_w-1:0] lane_addr;
    logic [lsu_pkg::word_w-1:0] lane_store_data;
    logic [$clog2(NUM_LANES)-1:0] lane;
    logic [NUM_LANES-1:0] seq_mask;
    logic gm_or_lds;
    logic seq_load;
    logic step;
    logic active;
    logic capture;
    logic load_data_en;

    lsu_opcode_decoder decoder_i (
        .issue_lsu_select (issue_lsu_select),
        .issue            (issue),
        .gpr_rd           (gpr_rd),
        .decoded          (decoded)
    );

    // register data lands one cycle after select, so the opcode is taken registered
    lsu_addr_calculator #(.NUM_LANES(NUM_LANES)) addr_calc_i (
        .opcode            (opcode_q),
        .lds_base          (lds_base_q),
        .sgpr_source1_data (sgpr_source1_data),
        .sgpr_source2_data (sgpr_source2_data),
        .vgpr_source1_data (vgpr_source1_data),
        .addrs             (addrs),
        .gm_or_lds         (gm_or_lds)
    );

    lsu_lane_sequencer #(.NUM_LANES(NUM_LANES)) sequencer_i (
        .clk    (clk),
        .rst    (rst),
        .load   (seq_load),
        .mask   (seq_mask),
        .step   (step),
        .lane   (lane),
        .active (active)
    );

    lsu_lane_buffer #(.NUM_LANES(NUM_LANES)) buffer_i (
        .clk             (clk),
        .rst             (rst),
        .capture         (capture),
        .addrs           (addrs),
        .store_data      (vgpr_source2_data),
        .lane            (lane),
        .load_data_en    (load_data_en),
        .mem_rd_data     (mem_rd_data),
        .lane_addr       (lane_addr),
        .lane_store_data (lane_store_data),
        .result          (result)
    );

    lsu_op_manager #(.NUM_LANES(NUM_LANES)) op_manager_i (
        .clk              (clk),
        .rst              (rst),
        .issue_lsu_select (issue_lsu_select),
        .issue            (issue),
        .exec_mask        (exec_mask),
        .decoded          (decoded),
        .active           (active),
        .lane_addr        (lane_addr),
        .lane_store_data  (lane_store_data),
        .result           (result),
        .gm_or_lds        (gm_or_lds),
        .mem_ack          (mem_ack),
        .issue_ready      (issue_ready),
        .opcode_q         (opcode_q),
        .lds_base_q       (lds_base_q),
        .seq_load         (seq_load),
        .seq_mask         (seq_mask),
        .step             (step),
        .capture          (capture),
        .load_data_en     (load_data_en),
        .mem_req          (mem_req),
        .wb               (wb),
        .done             (done)
    );

endmodule

`default_nettype wire

// File: lsu_addr_calculator.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_addr_calculator #(
    parameter int NUM_LANES = 4
) (
    input  wire lsu_pkg::lsu_opcode_u                     opcode,
    input  wire [15:0]                                     lds_base,
    input  wire [lsu_pkg::word_w-1:0]                      sgpr_source1_data,
    input  wire [lsu_pkg::word_w-1:0]                      sgpr_source2_data,
    input  wire [NUM_LANES-1:0][lsu_pkg::word_w-1:0]       vgpr_source1_data,
    output logic [NUM_LANES-1:0][lsu_pkg::word_w-1:0]      addrs,
    output logic                                           gm_or_lds
);

    logic is_smrd;
    logic is_ds;
    logic [lsu_pkg::word_w-1:0] smrd_off;
    logic [lsu_pkg::word_w-1:0] smrd_base;
    logic [lsu_pkg::word_w-1:0] vmem_base;

    assign is_smrd = (opcode.smrd.fmt == lsu_pkg::fmt_smrd);
    assign is_ds   = (opcode.vmem.fmt == lsu_pkg::fmt_ds);

    // smrd offset counts dwords
    assign smrd_off = opcode.smrd.imm ?
                      {{(lsu_pkg::word_w-8){1'b0}}, opcode.smrd.offset} : sgpr_source2_data;
    assign smrd_base = sgpr_source1_data + (smrd_off << 2);

    // global memory from the base scalar, LDS from its own base
    assign vmem_base = (is_ds ? {{(lsu_pkg::word_w-16){1'b0}}, lds_base} : sgpr_source1_data)
                     + {{(lsu_pkg::word_w-12){1'b0}}, opcode.vmem.offset};

    assign gm_or_lds = is_ds;

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        // for smrd the lane index is the dword index
        localparam logic [lsu_pkg::word_w-1:0] dw_off = 4 * k;

        assign addrs[k] = is_smrd ? smrd_base + dw_off : vmem_base + vgpr_source1_data[k];
    end

endmodule

`default_nettype wire

// File: lsu_lane_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_lane_buffer #(
    parameter int NUM_LANES = 4
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      capture,
    input  wire [NUM_LANES-1:0][lsu_pkg::word_w-1:0] addrs,
    input  wire [NUM_LANES-1:0][lsu_pkg::word_w-1:0] store_data,
    input  wire [$clog2(NUM_LANES)-1:0]              lane,
    input  wire                                      load_data_en,
    input  wire [lsu_pkg::word_w-1:0]                mem_rd_data,
    output logic [lsu_pkg::word_w-1:0]               lane_addr,
    output logic [lsu_pkg::word_w-1:0]               lane_store_data,
    output logic [NUM_LANES-1:0][lsu_pkg::word_w-1:0] result
);

    logic [NUM_LANES-1:0][lsu_pkg::word_w-1:0] addr_q;
    logic [NUM_LANES-1:0][lsu_pkg::word_w-1:0] data_q;
    logic [NUM_LANES-1:0][lsu_pkg::word_w-1:0] result_q;

    // addresses and store words are valid only in the capture cycle
    always_ff @(posedge clk) begin
        if (capture) begin
            addr_q <= addrs;
            data_q <= store_data;
        end
    end

    // lanes that never return data write back as zero
    always_ff @(posedge clk) begin
        if (rst || capture) begin
            result_q <= '0;
        end else if (load_data_en) begin
            result_q[lane] <= mem_rd_data;
        end
    end

    assign lane_addr       = addr_q[lane];
    assign lane_store_data = data_q[lane];
    // scalar write-back takes the low four words, vector write-back takes all
    assign result          = result_q;

endmodule

`default_nettype wire

// File: lsu_lane_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_lane_sequencer #(
    parameter int NUM_LANES = 4
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          load,
    input  wire [NUM_LANES-1:0]          mask,
    input  wire                          step,
    output logic [$clog2(NUM_LANES)-1:0] lane,
    output logic                         active
);

    localparam int lane_w = $clog2(NUM_LANES);

    logic [NUM_LANES-1:0] rem;
    logic [NUM_LANES-1:0] lane_bit;

    // lowest remaining lane goes first
    always_comb begin
        lane = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (rem[i]) begin
                lane = lane_w'(i);
            end
        end
    end

    assign lane_bit = {{(NUM_LANES-1){1'b0}}, 1'b1} << lane;
    assign active   = |rem;

    always_ff @(posedge clk) begin
        if (rst) begin
            rem <= '0;
        end else if (load) begin
            rem <= mask;
        end else if (step) begin
            rem <= rem & ~lane_bit;
        end
    end

endmodule

`default_nettype wire

// File: lsu_op_manager.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_op_manager #(
    parameter int NUM_LANES = 4
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      issue_lsu_select,
    input  wire lsu_pkg::lsu_issue_t                 issue,
    input  wire [NUM_LANES-1:0]                      exec_mask,
    input  wire lsu_pkg::lsu_decoded_t               decoded,
    input  wire                                      active,
    input  wire [lsu_pkg::word_w-1:0]                lane_addr,
    input  wire [lsu_pkg::word_w-1:0]                lane_store_data,
    input  wire [NUM_LANES-1:0][lsu_pkg::word_w-1:0] result,
    input  wire                                      gm_or_lds,
    input  wire                                      mem_ack,
    output logic                                     issue_ready,
    output lsu_pkg::lsu_opcode_u                     opcode_q,
    output logic [15:0]                              lds_base_q,
    output logic                                     seq_load,
    output logic [NUM_LANES-1:0]                     seq_mask,
    output logic                                     step,
    output logic                                     capture,
    output logic                                     load_data_en,
    output lsu_pkg::lsu_mem_req_t                    mem_req,
    output lsu_pkg::lsu_wb_t                         wb,
    output lsu_pkg::lsu_done_t                       done
);

    typedef enum logic [1:0] {
        st_idle,
        st_capture,
        st_request,
        st_wait_ack
    } state_e;

    state_e state;
    lsu_pkg::lsu_decoded_t dec_q;
    logic [lsu_pkg::wfid_w-1:0] wfid_q;
    logic [NUM_LANES-1:0] exec_q;
    logic is_smrd_q;
    logic [4:0] dw_ones;
    logic finishing;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (issue_lsu_select) begin
                        state <= st_capture;
                    end
                end
                st_capture:  state <= st_request;
                // request state finishes in place once no lane remains
                st_request:  state <= active ? st_wait_ack : st_idle;
                st_wait_ack: begin
                    if (mem_ack) begin
                        state <= st_request;
                    end
                end
                default:     state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && issue_lsu_select) begin
            opcode_q   <= issue.opcode;
            lds_base_q <= issue.lds_base;
            wfid_q     <= issue.wfid;
            dec_q      <= decoded;
            exec_q     <= exec_mask;
        end
    end

    assign is_smrd_q   = (dec_q.fmt == lsu_pkg::fmt_smrd);
    assign dw_ones     = (5'd1 << dec_q.dw_cnt) - 5'd1;
    assign issue_ready = (state == st_idle);
    assign capture     = (state == st_capture);
    assign seq_load    = capture;
    assign step        = (state == st_wait_ack) && mem_ack;
    assign load_data_en = step && !dec_q.store;
    assign finishing   = (state == st_request) && !active;

    // scalar loads walk dwords, vector ops walk exec lanes
    always_comb begin
        seq_mask = exec_q;
        if (is_smrd_q) begin
            seq_mask      = '0;
            seq_mask[3:0] = dw_ones[3:0];
        end
    end

    always_comb begin
        mem_req           = '0;
        mem_req.addr      = lane_addr;
        mem_req.wr_data   = lane_store_data;
        mem_req.gm_or_lds = gm_or_lds;
        if (state == st_request && active) begin
            mem_req.rd_en = !dec_q.store;
            mem_req.wr_en = dec_q.store;
        end
    end

    always_comb begin
        wb                = '0;
        wb.sgpr_dest_addr = dec_q.dest_addr[lsu_pkg::sgpr_addr_w-1:0];
        wb.sgpr_dest_data = result[3:0];
        wb.vgpr_dest_addr = dec_q.dest_addr[lsu_pkg::vgpr_addr_w-1:0];
        wb.vgpr_dest_wr_mask[NUM_LANES-1:0] = exec_q;
        wb.vgpr_dest_data[NUM_LANES-1:0]    = result;
        if (finishing && !dec_q.store) begin
            if (is_smrd_q) begin
                wb.sgpr_dest_wr_en = dw_ones[3:0];
            end else begin
                wb.vgpr_dest_wr_en = 1'b1;
            end
        end
    end

    always_comb begin
        done      = '0;
        done.wfid = wfid_q;
        if (finishing) begin
            done.lsu_done        = 1'b1;
            done.sgpr_instr_done = is_smrd_q;
            done.vgpr_instr_done = !is_smrd_q;
        end
    end

endmodule

`default_nettype wire

// File: lsu_opcode_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_opcode_decoder (
    input  wire                   issue_lsu_select,
    input  wire lsu_pkg::lsu_issue_t issue,
    output lsu_pkg::lsu_gpr_rd_t  gpr_rd,
    output lsu_pkg::lsu_decoded_t decoded
);

    lsu_pkg::lsu_fmt_e fmt;
    logic is_smrd;
    logic is_store;

    // both views keep the format in the same bits
    assign fmt      = issue.opcode.smrd.fmt;
    assign is_smrd  = (fmt == lsu_pkg::fmt_smrd);
    assign is_store = !is_smrd && issue.opcode.vmem.store;

    always_comb begin
        gpr_rd = '0;
        gpr_rd.sgpr_source1_rd_en = issue_lsu_select;
        gpr_rd.sgpr_source1_addr  = issue.base_reg[lsu_pkg::sgpr_addr_w-1:0];
        // scalar offset register only when no immediate is given
        gpr_rd.sgpr_source2_rd_en = issue_lsu_select && is_smrd && !issue.opcode.smrd.imm;
        gpr_rd.sgpr_source2_addr  = issue.addr_reg[lsu_pkg::sgpr_addr_w-1:0];
        gpr_rd.vgpr_source1_rd_en = issue_lsu_select && !is_smrd;
        gpr_rd.vgpr_source1_addr  = issue.addr_reg[lsu_pkg::vgpr_addr_w-1:0];
        // store data comes from the second vector source
        gpr_rd.vgpr_source2_rd_en = issue_lsu_select && is_store;
        gpr_rd.vgpr_source2_addr  = issue.data_reg[lsu_pkg::vgpr_addr_w-1:0];
    end

    always_comb begin
        decoded.fmt       = fmt;
        decoded.store     = is_store;
        decoded.dest_addr = issue.dest_reg;
        case (issue.opcode.smrd.dw_code)
            2'd0:    decoded.dw_cnt = 3'd1;
            2'd1:    decoded.dw_cnt = 3'd2;
            default: decoded.dw_cnt = 3'd4;
        endcase
    end

endmodule

`default_nettype wire

// File: lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int word_w = 32;
    localparam int sgpr_addr_w = 9;
    localparam int vgpr_addr_w = 10;
    localparam int wfid_w = 6;
    // widest lane count that the vector write-back bundle can carry
    localparam int max_lanes = 16;

    // format class sits in the top two opcode bits
    typedef enum logic [1:0] {
        fmt_smrd  = 2'd0,
        fmt_mubuf = 2'd1,
        fmt_ds    = 2'd2
    } lsu_fmt_e;

    // scalar view where dw_code 0/1/2 selects 1/2/4 dwords
    typedef struct packed {
        lsu_fmt_e    fmt;
        logic [18:0] rsvd;
        logic [1:0]  dw_code;
        logic        imm;
        logic [7:0]  offset;
    } lsu_smrd_fields_t;

    // vector view with the offset in bytes
    typedef struct packed {
        lsu_fmt_e    fmt;
        logic [16:0] rsvd;
        logic        store;
        logic [11:0] offset;
    } lsu_vmem_fields_t;

    typedef union packed {
        lsu_smrd_fields_t smrd;
        lsu_vmem_fields_t vmem;
    } lsu_opcode_u;

    typedef struct packed {
        logic [wfid_w-1:0] wfid;
        lsu_opcode_u       opcode;
        logic [11:0]       addr_reg;
        logic [11:0]       data_reg;
        logic [11:0]       base_reg;
        logic [11:0]       dest_reg;
        logic [15:0]       lds_base;
    } lsu_issue_t;

    typedef struct packed {
        logic                   sgpr_source1_rd_en;
        logic [sgpr_addr_w-1:0] sgpr_source1_addr;
        logic                   sgpr_source2_rd_en;
        logic [sgpr_addr_w-1:0] sgpr_source2_addr;
        logic                   vgpr_source1_rd_en;
        logic [vgpr_addr_w-1:0] vgpr_source1_addr;
        logic                   vgpr_source2_rd_en;
        logic [vgpr_addr_w-1:0] vgpr_source2_addr;
    } lsu_gpr_rd_t;

    typedef struct packed {
        lsu_fmt_e    fmt;
        logic        store;
        logic [2:0]  dw_cnt;
        logic [11:0] dest_addr;
    } lsu_decoded_t;

    typedef struct packed {
        logic              rd_en;
        logic              wr_en;
        logic [word_w-1:0] addr;
        logic [word_w-1:0] wr_data;
        logic              gm_or_lds;
    } lsu_mem_req_t;

    typedef struct packed {
        logic [3:0]                          sgpr_dest_wr_en;
        logic [sgpr_addr_w-1:0]              sgpr_dest_addr;
        logic [4*word_w-1:0]                 sgpr_dest_data;
        logic                                vgpr_dest_wr_en;
        logic [vgpr_addr_w-1:0]              vgpr_dest_addr;
        logic [max_lanes-1:0]                vgpr_dest_wr_mask;
        logic [max_lanes-1:0][word_w-1:0]    vgpr_dest_data;
    } lsu_wb_t;

    typedef struct packed {
        logic              lsu_done;
        logic              sgpr_instr_done;
        logic              vgpr_instr_done;
        logic [wfid_w-1:0] wfid;
    } lsu_done_t;

endpackage

`default_nettype wire

// File: lsu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

    localparam int NUM_LANES = 4;

    logic clk;
    logic rst;
    logic issue_lsu_select;
    lsu_pkg::lsu_issue_t issue;
    logic [NUM_LANES-1:0] exec_mask;
    logic issue_ready;
    lsu_pkg::lsu_gpr_rd_t gpr_rd;
    logic [31:0] sgpr_source1_data;
    logic [31:0] sgpr_source2_data;
    logic [NUM_LANES-1:0][31:0] vgpr_source1_data;
    logic [NUM_LANES-1:0][31:0] vgpr_source2_data;
    lsu_pkg::lsu_mem_req_t mem_req;
    logic mem_ack;
    logic [31:0] mem_rd_data;
    lsu_pkg::lsu_wb_t wb;
    lsu_pkg::lsu_done_t done;

    logic [31:0] mem [256];
    lsu_pkg::lsu_gpr_rd_t rd_q;
    logic [31:0] seed;
    logic [7:0] req_idx;
    int cyc;
    int limit;
    int cur_lat;
    int wait_left;
    int last_ack_cyc;
    bit pend;
    string cur_name;
    int errs;
    int n_pass;
    int n_fail;

    // stimulus table with one entry per row
    string t_name[$];
    int t_fmt[$];
    int t_store[$];
    int t_dw[$];
    int t_imm[$];
    int t_off[$];
    int t_areg[$];
    int t_dreg[$];
    int t_breg[$];
    int t_dest[$];
    int t_lds[$];
    int t_exec[$];
    int t_lat[$];

    lsu #(.NUM_LANES(NUM_LANES)) lsu_i (
        .clk (clk), .rst (rst),
        .issue_lsu_select (issue_lsu_select), .issue (issue), .exec_mask (exec_mask),
        .issue_ready (issue_ready), .gpr_rd (gpr_rd),
        .sgpr_source1_data (sgpr_source1_data), .sgpr_source2_data (sgpr_source2_data),
        .vgpr_source1_data (vgpr_source1_data), .vgpr_source2_data (vgpr_source2_data),
        .mem_req (mem_req), .mem_ack (mem_ack), .mem_rd_data (mem_rd_data),
        .wb (wb), .done (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // register files answer one cycle after the read enable
    always @(negedge clk) begin
        rd_q = gpr_rd;
    end

    always @(posedge clk) begin
        #1;
        if (rd_q.sgpr_source1_rd_en) sgpr_source1_data = 16 * rd_q.sgpr_source1_addr + 3;
        if (rd_q.sgpr_source2_rd_en) sgpr_source2_data = 16 * rd_q.sgpr_source2_addr + 3;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (rd_q.vgpr_source1_rd_en) begin
                vgpr_source1_data[l] = 256 * rd_q.vgpr_source1_addr + 4 * l;
            end
            if (rd_q.vgpr_source2_rd_en) begin
                vgpr_source2_data[l] = 256 * rd_q.vgpr_source2_addr + 4 * l;
            end
        end
    end

    // memory model applies writes when the request is seen
    always @(negedge clk) begin
        if (mem_req.rd_en || mem_req.wr_en) begin
            pend = 1'b1;
            wait_left = cur_lat;
            req_idx = mem_req.addr[9:2];
            if (mem_req.wr_en) mem[req_idx] = mem_req.wr_data;
        end
    end

    always @(posedge clk) begin
        #1;
        mem_ack = 1'b0;
        if (pend) begin
            wait_left--;
            if (wait_left == 0) begin
                mem_ack = 1'b1;
                mem_rd_data = mem[req_idx];
                pend = 1'b0;
                last_ack_cyc = cyc;
            end
        end
    end

    task automatic check_word(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, act);
            errs++;
        end
    endtask

    task automatic report(string msg);
        $display("%s: %s", cur_name, msg);
        errs++;
    endtask

    task automatic add_row(string name, int fmt, int store, int dw, int imm, int off,
                           int areg, int dreg, int breg, int dest, int lds, int exec,
                           int lat);
        t_name.push_back(name);
        t_fmt.push_back(fmt);
        t_store.push_back(store);
        t_dw.push_back(dw);
        t_imm.push_back(imm);
        t_off.push_back(off);
        t_areg.push_back(areg);
        t_dreg.push_back(dreg);
        t_breg.push_back(breg);
        t_dest.push_back(dest);
        t_lds.push_back(lds);
        t_exec.push_back(exec);
        t_lat.push_back(lat);
    endtask

    task automatic finish_test();
        if (errs == 0) begin
            $display("test %s ok", cur_name);
            n_pass++;
        end else begin
            $display("test %s failed with %0d errors", cur_name, errs);
            n_fail++;
        end
    endtask

    task automatic run_row(int r);
        logic [31:0] word;
        logic [3:0] mask;
        logic [3:0] exp_rd;
        logic [3:0] act_rd;
        logic [31:0] exp_addr[4];
        logic [31:0] exp_data[4];
        logic [31:0] exp_load[4];
        int lanes[$];
        int dw;
        int off_dw;
        int base;
        int n_req;
        int sel_cyc;
        int wb_seen;
        int l;
        cur_name = t_name[r];
        cur_lat = t_lat[r];
        errs = 0;
        n_req = 0;
        wb_seen = 0;
        dw = 1 << t_dw[r];
        if (t_fmt[r] == 0) begin
            word = {2'd0, 19'd0, 2'(t_dw[r]), 1'(t_imm[r]), 8'(t_off[r])};
            mask = '0;
            for (int k = 0; k < dw; k++) begin
                mask[k] = 1'b1;
            end
            off_dw = (t_imm[r] != 0) ? t_off[r] : 16 * t_areg[r] + 3;
            base = 16 * t_breg[r] + 3 + 4 * off_dw;
        end else begin
            word = {2'(t_fmt[r]), 17'd0, 1'(t_store[r]), 12'(t_off[r])};
            mask = 4'(t_exec[r]);
            base = ((t_fmt[r] == 2) ? t_lds[r] : 16 * t_breg[r] + 3) + t_off[r];
        end
        for (int k = 0; k < 4; k++) begin
            exp_addr[k] = (t_fmt[r] == 0) ? base + 4 * k : base + 256 * t_areg[r] + 4 * k;
            exp_data[k] = 256 * t_dreg[r] + 4 * k;
            exp_load[k] = mem[exp_addr[k][9:2]];
            if (mask[k]) lanes.push_back(k);
        end
        // base scalar always, offset scalar without immediate, vector address, store data
        exp_rd[3] = 1'b1;
        exp_rd[2] = (t_fmt[r] == 0) && (t_imm[r] == 0);
        exp_rd[1] = (t_fmt[r] != 0);
        exp_rd[0] = (t_store[r] != 0);

        @(posedge clk);
        #1;
        if (issue_ready !== 1'b1) report("issue_ready low before select");
        issue_lsu_select = 1'b1;
        issue = '0;
        issue.wfid = 6'(r + 9);
        issue.opcode = word;
        issue.addr_reg = 12'(t_areg[r]);
        issue.data_reg = 12'(t_dreg[r]);
        issue.base_reg = 12'(t_breg[r]);
        issue.dest_reg = 12'(t_dest[r]);
        issue.lds_base = 16'(t_lds[r]);
        exec_mask = 4'(t_exec[r]);
        sel_cyc = cyc;
        @(negedge clk);
        act_rd = {gpr_rd.sgpr_source1_rd_en, gpr_rd.sgpr_source2_rd_en,
                  gpr_rd.vgpr_source1_rd_en, gpr_rd.vgpr_source2_rd_en};
        check_word("read enables", 32'(exp_rd), 32'(act_rd));
        @(posedge clk);
        #1;
        issue_lsu_select = 1'b0;
        if (issue_ready !== 1'b0) report("issue_ready still high after select");

        do begin
            @(negedge clk);
            if (mem_req.rd_en || mem_req.wr_en) begin
                if (n_req >= lanes.size()) begin
                    report("request for a lane that is not active");
                end else begin
                    l = lanes[n_req];
                    check_word("addr", exp_addr[l], mem_req.addr);
                    check_word("rd_en", 32'(t_store[r] == 0), 32'(mem_req.rd_en));
                    check_word("wr_en", 32'(t_store[r]), 32'(mem_req.wr_en));
                    if (t_store[r] != 0) check_word("wr_data", exp_data[l], mem_req.wr_data);
                    check_word("gm_or_lds", 32'(t_fmt[r] == 2), 32'(mem_req.gm_or_lds));
                    check_word("req cycle", (n_req == 0) ? sel_cyc + 2 : last_ack_cyc + 1, cyc);
                end
                n_req++;
            end
            if (wb.sgpr_dest_wr_en != 4'd0 || wb.vgpr_dest_wr_en) begin
                wb_seen++;
                if (!done.lsu_done) report("write-back pulse without done");
                if (t_fmt[r] == 0) begin
                    check_word("sgpr en", 32'(mask), 32'(wb.sgpr_dest_wr_en));
                    check_word("sgpr dest", 32'(t_dest[r]), 32'(wb.sgpr_dest_addr));
                    for (int k = 0; k < dw; k++)
                        check_word("sgpr data", exp_load[k], wb.sgpr_dest_data[32*k +: 32]);
                end else begin
                    check_word("vgpr mask", 32'(mask), 32'(wb.vgpr_dest_wr_mask[3:0]));
                    check_word("vgpr dest", 32'(t_dest[r]), 32'(wb.vgpr_dest_addr));
                    foreach (lanes[i])
                        check_word("vgpr data", exp_load[lanes[i]], wb.vgpr_dest_data[lanes[i]]);
                end
            end
        end while (!done.lsu_done);

        check_word("requests", lanes.size(), n_req);
        check_word("wfid", 32'(r + 9), 32'(done.wfid));
        check_word("sgpr done", 32'(t_fmt[r] == 0), 32'(done.sgpr_instr_done));
        check_word("vgpr done", 32'(t_fmt[r] != 0), 32'(done.vgpr_instr_done));
        if (lanes.size() == 0) begin
            check_word("done cycle", sel_cyc + 2, cyc);
        end else begin
            check_word("done cycle", last_ack_cyc + 1, cyc);
        end
        check_word("write-backs", (t_store[r] != 0) ? 0 : 1, wb_seen);
        if (t_store[r] != 0) begin
            foreach (lanes[i])
                check_word("memory", exp_data[lanes[i]], mem[exp_addr[lanes[i]][9:2]]);
        end
        @(negedge clk);
        if (issue_ready !== 1'b1) report("issue_ready not back high the cycle after done");
        finish_test();
    endtask

    initial begin
        cyc = 0;
        limit = 1000;
        pend = 1'b0;
        last_ack_cyc = 0;
        cur_lat = 1;
        n_pass = 0;
        n_fail = 0;
        rst = 1'b1;
        issue_lsu_select = 1'b0;
        issue = '0;
        exec_mask = '0;
        sgpr_source1_data = '0;
        sgpr_source2_data = '0;
        vgpr_source1_data = '0;
        vgpr_source2_data = '0;
        mem_ack = 1'b0;
        mem_rd_data = '0;
        seed = 32'h06f7131b;
        for (int i = 0; i < 256; i++) begin
            seed = lcg_next(seed);
            mem[i] = seed;
        end

        // name, fmt, store, dw code, imm, offset, areg, dreg, breg, dest, lds, exec, latency
        add_row("smrd_x1_imm",  0, 0, 0, 1,  5, 0, 0, 2, 20,     0, 4'hf, 1);
        add_row("smrd_x2_sreg", 0, 0, 1, 0,  0, 3, 0, 1, 24,     0, 4'hf, 2);
        add_row("smrd_x4_imm",  0, 0, 2, 1,  7, 0, 0, 4, 28,     0, 4'hf, 5);
        add_row("mubuf_load",   1, 0, 0, 0, 12, 1, 0, 2, 40,     0, 4'ha, 3);
        add_row("mubuf_store",  1, 1, 0, 0,  8, 2, 5, 3,  0,     0, 4'h7, 1);
        add_row("ds_store",     2, 1, 0, 0, 16, 1, 6, 0,  0, 16'h40, 4'hd, 5);
        add_row("ds_load",      2, 0, 0, 0,  4, 1, 0, 0, 44, 16'h40, 4'hf, 1);
        add_row("empty_exec",   1, 1, 0, 0,  0, 1, 2, 0,  0,     0, 4'h0, 1);
        limit = t_name.size() * 80;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        cur_name = "reset_idle";
        errs = 0;
        repeat (3) begin
            @(negedge clk);
            if (issue_ready !== 1'b1) report("issue_ready low while idle");
            if (mem_req.rd_en || mem_req.wr_en) report("request while idle");
            if (wb.sgpr_dest_wr_en != 4'd0 || wb.vgpr_dest_wr_en) report("write-back while idle");
            if (done.lsu_done) report("done pulse while idle");
        end
        finish_test();

        for (int r = 0; r < t_name.size(); r++) begin
            run_row(r);
        end

        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
